// ==== src/ipod_pkg.sv ====
`default_nettype none

package ipod_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int ADDR_W   = 23;          // Flash byte address
  localparam int DATA_W   = 32;          // Flash word
  localparam int SAMPLE_W = 8;
  localparam int PERIOD_W = 16;
  localparam int HALF_W   = DATA_W / 2;  // One 16-bit audio sample per half
  localparam int INDEX_W  = ADDR_W - 1;  // Two samples per 4-byte word

  // ==================================================
  // Speed control
  // ==================================================
  // Kept small so simulation runs many samples quickly
  localparam logic [PERIOD_W-1:0] DEFAULT_PERIOD = 16;
  localparam logic [PERIOD_W-1:0] SPEED_STEP     = 4;
  localparam logic [PERIOD_W-1:0] MIN_PERIOD     = 4;
  localparam logic [PERIOD_W-1:0] MAX_PERIOD     = 64;

  localparam logic [1:0]          RESP_OKAY = 2'b00;
  localparam logic [SAMPLE_W-1:0] SILENCE   = 8'h00;  // Played on a bad read

  // Key commands, at most one per cycle
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_FASTER,
    CMD_SLOWER,
    CMD_RESET_SPEED,
    CMD_TOGGLE_PLAY,
    CMD_TOGGLE_DIR
  } cmd_t;

  // Flash read sequencer
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,  // arvalid high
    RD_DATA   // rready high
  } rd_state_t;

  typedef struct packed {
    logic speed_up;
    logic speed_down;
    logic speed_reset;
    logic play;
    logic dir;
  } keys_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] araddr;
    logic [2:0]        arprot;
  } ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } r_t;

  typedef struct packed {
    logic [DATA_W-1:0] word;
    logic [1:0]        resp;
    logic              upper_half;  // Odd sample index
  } fetch_t;

endpackage

`default_nettype wire

// ==== src/key_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module key_decode import ipod_pkg::*;
(
  input  logic  CLK_50M,
  input  logic  rst_n,
  input  keys_t keys,
  output cmd_t  cmd
);

  keys_t sync_meta;  // First synchronizer stage
  keys_t sync_keys;  // Safe to use from here on
  keys_t keys_prev;
  keys_t key_rise;
  cmd_t  cmd_next;

  // ==================================================
  // Synchronizer and edge detect
  // ==================================================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_meta <= '0;
      sync_keys <= '0;
      keys_prev <= '0;
      key_rise  <= '0;
    end
    else
    begin
      sync_meta <= keys;
      sync_keys <= sync_meta;
      keys_prev <= sync_keys;
      key_rise  <= sync_keys & ~keys_prev;  // One cycle per press
    end
  end

  // Highest priority edge wins when keys rise together
  always_comb
  begin
    cmd_next = CMD_NONE;
    if (key_rise.speed_reset)
      cmd_next = CMD_RESET_SPEED;
    else if (key_rise.speed_up)
      cmd_next = CMD_FASTER;
    else if (key_rise.speed_down)
      cmd_next = CMD_SLOWER;
    else if (key_rise.play)
      cmd_next = CMD_TOGGLE_PLAY;
    else if (key_rise.dir)
      cmd_next = CMD_TOGGLE_DIR;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cmd <= CMD_NONE;
    end
    else
    begin
      cmd <= cmd_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/playback_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module playback_execute import ipod_pkg::*;
#(
  parameter int unsigned last_index = 2**20 - 1
)
(
  input  logic                CLK_50M,
  input  logic                rst_n,
  input  cmd_t                cmd,
  output ar_t                 ar,
  output logic                arvalid,
  input  logic                arready,
  input  r_t                  r,
  input  logic                rvalid,
  output logic                rready,
  output fetch_t              fetch,
  output logic                fetch_valid,
  output logic [PERIOD_W-1:0] sample_period
);

  logic [PERIOD_W-1:0] next_period;
  logic [PERIOD_W-1:0] div_cnt;
  logic                speed_cmd;
  logic                tick;
  logic                playing;
  logic                forward;
  rd_state_t           rd_state;
  logic [INDEX_W-1:0]  index;
  logic [INDEX_W-1:0]  next_index;
  logic                ar_hs;
  logic                r_hs;

  // ==================================================
  // Speed register and sample tick
  // ==================================================
  always_comb
  begin
    next_period = sample_period;
    speed_cmd   = 1'b1;
    case (cmd)
      CMD_FASTER:
        if (sample_period >= MIN_PERIOD + SPEED_STEP)
          next_period = sample_period - SPEED_STEP;
        else
          next_period = MIN_PERIOD;
      CMD_SLOWER:
        if (sample_period <= MAX_PERIOD - SPEED_STEP)
          next_period = sample_period + SPEED_STEP;
        else
          next_period = MAX_PERIOD;
      CMD_RESET_SPEED:
        next_period = DEFAULT_PERIOD;
      default:
        speed_cmd = 1'b0;
    endcase
  end

  // A speed change restarts the divider so ticks never crowd together
  assign tick = (div_cnt == '0) && !speed_cmd;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_period <= DEFAULT_PERIOD;
      div_cnt       <= DEFAULT_PERIOD;
      playing       <= 1'b1;
      forward       <= 1'b1;
    end
    else
    begin
      sample_period <= next_period;
      if (speed_cmd)
        div_cnt <= next_period;
      else if (div_cnt == '0)
        div_cnt <= sample_period;  // Period + 1 cycles per tick
      else
        div_cnt <= div_cnt - 1'b1;
      if (cmd == CMD_TOGGLE_PLAY)
        playing <= !playing;
      if (cmd == CMD_TOGGLE_DIR)
        forward <= !forward;
    end
  end

  // ==================================================
  // Flash read sequencer
  // ==================================================
  assign arvalid = (rd_state == RD_ADDR);
  assign rready  = (rd_state == RD_DATA);
  assign ar_hs   = arvalid && arready;
  assign r_hs    = rready && rvalid;

  // Index only moves at the R handshake, so ar holds steady while arvalid is up
  assign ar = '{araddr: {index[INDEX_W-1:1], 2'b00}, arprot: 3'b000};

  // Wrap at both ends of the track
  always_comb
  begin
    if (forward)
      next_index = (index == INDEX_W'(last_index)) ? '0 : index + 1'b1;
    else
      next_index = (index == '0) ? INDEX_W'(last_index) : index - 1'b1;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_state    <= RD_IDLE;
      index       <= '0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      fetch_valid <= 1'b0;
      case (rd_state)
        RD_IDLE:
          if (tick && playing)  // Ticks in other states are dropped
            rd_state <= RD_ADDR;
        RD_ADDR:
          if (ar_hs)
            rd_state <= RD_DATA;
        RD_DATA:
          if (r_hs)
          begin
            rd_state    <= RD_IDLE;
            index       <= next_index;
            fetch_valid <= 1'b1;
          end
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  // Returned beat and which half of it to play
  always_ff @(posedge CLK_50M)
  begin
    if (r_hs)
    begin
      fetch.word       <= r.rdata;
      fetch.resp       <= r.rresp;
      fetch.upper_half <= index[0];
    end
  end

endmodule

`default_nettype wire

// ==== src/sample_result.sv ====
`timescale 1ns/10ps
`default_nettype none

module sample_result import ipod_pkg::*;
(
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  fetch_t                     fetch,
  input  logic                       fetch_valid,
  output logic signed [SAMPLE_W-1:0] sample,
  output logic                       sample_valid
);

  logic [HALF_W-1:0]   half_word;
  logic [SAMPLE_W-1:0] sample_next;

  // Odd index lives in the upper half of the word
  assign half_word = fetch.upper_half ? fetch.word[DATA_W-1 -: HALF_W]
                                      : fetch.word[HALF_W-1:0];

  always_comb
  begin
    if (fetch.resp != RESP_OKAY)
      sample_next = SILENCE;  // Bad read plays as silence
    else
      sample_next = half_word[HALF_W-1 -: SAMPLE_W];  // Keep the top byte only
  end

  // ==================================================
  // Output register
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (fetch_valid)
      sample <= sample_next;
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= fetch_valid;  // One strobe per fetched word
    end
  end

endmodule

`default_nettype wire

// ==== src/ipod_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ipod_top import ipod_pkg::*;
#(
  parameter int unsigned last_index = 2**20 - 1
)
(
  input  logic                       CLK_50M,
  input  logic                       rst_n,
  input  keys_t                      keys,
  // Flash read channels
  output ar_t                        ar,
  output logic                       arvalid,
  input  logic                       arready,
  input  r_t                         r,
  input  logic                       rvalid,
  output logic                       rready,
  // Audio out
  output logic signed [SAMPLE_W-1:0] sample,
  output logic                       sample_valid,
  output logic [PERIOD_W-1:0]        sample_period
);

  cmd_t   cmd;
  fetch_t fetch;
  logic   fetch_valid;

  key_decode u_key_decode (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .keys    (keys),
    .cmd     (cmd)
  );

  // Speed, tick and flash reads
  playback_execute #(
    .last_index (last_index)
  ) u_playback_execute (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .ar            (ar),
    .arvalid       (arvalid),
    .arready       (arready),
    .r             (r),
    .rvalid        (rvalid),
    .rready        (rready),
    .fetch         (fetch),
    .fetch_valid   (fetch_valid),
    .sample_period (sample_period)
  );

  sample_result u_sample_result (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .fetch        (fetch),
    .fetch_valid  (fetch_valid),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock
(
  output logic CLK_50M,
  output logic rst_n
);

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;  // 20 ns period
  end

  // Reset held over the first 4 rising edges
  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge CLK_50M);
    #2 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/ipod_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module ipod_asserts import ipod_pkg::*;
#(
  parameter int unsigned last_index = 2**20 - 1
)
(
  input logic                       CLK_50M,
  input logic                       rst_n,
  input keys_t                      keys,
  input ar_t                        ar,
  input logic                       arvalid,
  input logic                       arready,
  input r_t                         r,
  input logic                       rvalid,
  input logic                       rready,
  input logic signed [SAMPLE_W-1:0] sample,
  input logic                       sample_valid,
  input logic [PERIOD_W-1:0]        sample_period
);

  int unsigned         fail_count = 0;
  keys_t               keys_q;
  logic [3:0]          play_pipe;  // Key rise until the command lands
  logic [3:0]          dir_pipe;
  logic                exp_playing;
  logic                exp_fwd;
  int unsigned         exp_index;
  logic [SAMPLE_W-1:0] exp_sample;
  logic                ar_done;    // Address taken, data still due
  logic                arvalid_q;
  logic                seen_ar;
  int unsigned         since_ar;   // Cycles since the last read started
  logic                r_hs;

  function automatic int clamp_period(input int p);
    if (p < int'(MIN_PERIOD))
      return int'(MIN_PERIOD);
    if (p > int'(MAX_PERIOD))
      return int'(MAX_PERIOD);
    return p;
  endfunction

  function automatic int unsigned step_index(input int unsigned idx, input logic fwd);
    if (fwd)
      return (idx == last_index) ? 0 : idx + 1;
    return (idx == 0) ? last_index : idx - 1;
  endfunction

  task automatic flag_failure(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  // ==================================================
  // Reference model of the player state
  // ==================================================
  assign r_hs = rready && rvalid;

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      keys_q      <= '0;
      play_pipe   <= '0;
      dir_pipe    <= '0;
      exp_playing <= 1'b1;
      exp_fwd     <= 1'b1;
      exp_index   <= 0;
      exp_sample  <= '0;
      ar_done     <= 1'b0;
      arvalid_q   <= 1'b0;
      seen_ar     <= 1'b0;
      since_ar    <= 0;
    end
    else
    begin
      keys_q    <= keys;
      play_pipe <= {play_pipe[2:0], keys.play && !keys_q.play};
      dir_pipe  <= {dir_pipe[2:0], keys.dir && !keys_q.dir};
      if (play_pipe[3])
        exp_playing <= !exp_playing;
      if (dir_pipe[3])
        exp_fwd <= !exp_fwd;
      if (arvalid && arready)
        ar_done <= 1'b1;
      if (r_hs)
      begin
        ar_done   <= 1'b0;
        exp_index <= step_index(exp_index, exp_fwd);
        if (r.rresp != RESP_OKAY)
          exp_sample <= SILENCE;
        else
          exp_sample <= exp_index[0] ? r.rdata[31:24] : r.rdata[15:8];  // Odd is upper
      end
      arvalid_q <= arvalid;
      if (arvalid && !arvalid_q)
      begin
        seen_ar  <= 1'b1;
        since_ar <= 1;
      end
      else if (since_ar < 32'hFFFF)
        since_ar <= since_ar + 1;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  // Covers every cycle held in reset and the first cycle after release
  a_reset_state: assert property (@(posedge CLK_50M) !rst_n |=>
      (!arvalid && !rready && !sample_valid && sample_period == DEFAULT_PERIOD))
    else flag_failure("outputs not idle or period not default around reset");

  a_faster: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      $rose(keys.speed_up) |-> ##4 $stable(sample_period) ##1
      (int'(sample_period) == clamp_period(int'($past(sample_period)) - int'(SPEED_STEP))))
    else flag_failure("speed_up did not lower the period 4 cycles after the press");

  a_slower: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      $rose(keys.speed_down) |-> ##4 $stable(sample_period) ##1
      (int'(sample_period) == clamp_period(int'($past(sample_period)) + int'(SPEED_STEP))))
    else flag_failure("speed_down did not raise the period 4 cycles after the press");

  a_speed_reset: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      $rose(keys.speed_reset) |-> ##4 $stable(sample_period) ##1
      (sample_period == DEFAULT_PERIOD))
    else flag_failure("speed_reset did not restore the default period");

  a_sample_delay: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      r_hs |-> ##2 sample_valid)
    else flag_failure("no sample_valid 2 cycles after the R handshake");

  a_sample_value: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      sample_valid |-> ($past(r_hs, 2) && sample == exp_sample))
    else flag_failure("sample value or strobe does not match the returned word");

  a_address: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      arvalid |-> (ar.araddr == ADDR_W'(exp_index / 2 * 4) && ar.arprot == 3'b000))
    else flag_failure("read address does not follow the sample index");

  a_paused: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      $rose(arvalid) |-> $past(exp_playing))
    else flag_failure("read started while paused");

  a_ar_hold: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      (arvalid && !arready) |=> (arvalid && $stable(ar)))
    else flag_failure("arvalid dropped or ar changed before arready");

  a_rready_window: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      rready |-> ar_done)
    else flag_failure("rready high outside the AR to R window");

  a_single_read: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      arvalid |-> !ar_done)
    else flag_failure("second read issued while one is outstanding");

  a_read_spacing: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      (arvalid && !arvalid_q && seen_ar) |-> (since_ar > sample_period))
    else flag_failure("reads closer together than sample_period + 1 cycles");

endmodule

bind ipod_top ipod_asserts #(
  .last_index (last_index)
) u_asserts (
  .CLK_50M       (CLK_50M),
  .rst_n         (rst_n),
  .keys          (keys),
  .ar            (ar),
  .arvalid       (arvalid),
  .arready       (arready),
  .r             (r),
  .rvalid        (rvalid),
  .rready        (rready),
  .sample        (sample),
  .sample_valid  (sample_valid),
  .sample_period (sample_period)
);

`default_nettype wire

// ==== bench/tb_ipod.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_ipod import ipod_pkg::*;
();

  localparam int     CLK_NS     = 20;
  localparam int     PHASES     = 6;
  // 40 sample periods at the slowest speed for every phase
  localparam longint TIMEOUT_NS = longint'(PHASES) * 40 * (MAX_PERIOD + 1) * CLK_NS;

  logic                       CLK_50M;
  logic                       rst_n;
  keys_t                      keys;
  ar_t                        ar;
  logic                       arvalid;
  logic                       arready;
  r_t                         r;
  logic                       rvalid;
  logic                       rready;
  logic signed [SAMPLE_W-1:0] sample;
  logic                       sample_valid;
  logic [PERIOD_W-1:0]        sample_period;
  logic [31:0]                lfsr = 32'h4025;

  tb_clock u_clock (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n)
  );

  ipod_top #(
    .last_index (15)  // Short track so both wraps come quickly
  ) dut0 (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .keys          (keys),
    .ar            (ar),
    .arvalid       (arvalid),
    .arready       (arready),
    .r             (r),
    .rvalid        (rvalid),
    .rready        (rready),
    .sample        (sample),
    .sample_valid  (sample_valid),
    .sample_period (sample_period)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic draw_delay(output int cycles);
    cycles = 0;
    repeat (2)
    begin
      lfsr   = lfsr_next(lfsr);
      cycles = cycles * 2 + lfsr[0];  // One step per bit
    end
  endtask

  task automatic step_cycle();
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic press_key(input keys_t k);
    step_cycle();
    keys = k;
    repeat (4) step_cycle();
    keys = '0;
    repeat (6) step_cycle();
  endtask

  task automatic wait_samples(input int n);
    int count;
    count = 0;
    while (count < n)
    begin
      step_cycle();
      if (sample_valid)
        count++;
    end
  endtask

  // ==================================================
  // Flash model with random channel stalls
  // ==================================================
  initial
  begin : flash_responder
    int                delay;
    logic [ADDR_W-1:0] addr;
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    forever
    begin
      step_cycle();
      if (arvalid)
      begin
        draw_delay(delay);
        repeat (delay) step_cycle();
        addr    = ar.araddr;
        arready = 1'b1;
        step_cycle();
        arready = 1'b0;
        draw_delay(delay);
        repeat (delay) step_cycle();
        // Address byte in every lane, top lane inverted so the halves differ
        r.rdata = {~addr[7:0], addr[7:0], addr[7:0], addr[7:0]};
        r.rresp = (addr == 'h1C) ? 2'b10 : RESP_OKAY;  // SLVERR on one word
        rvalid  = 1'b1;
        step_cycle();
        rvalid  = 1'b0;
      end
    end
  end

  always @(negedge CLK_50M)
  begin
    if (dut0.u_asserts.fail_count != 0)
    begin
      $display("ERROR at %0t ns: assertion failed in ipod_asserts", $time);
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the test did not finish within %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $fatal(1);
  end

  // ==================================================
  // Test phases
  // ==================================================
  initial
  begin
    keys = '0;
    @(posedge rst_n);
    wait_samples(20);  // Forward through the wrap from 15 to 0
    repeat (16) press_key(keys_t'{speed_down: 1'b1, default: 1'b0});
    wait_samples(2);
    press_key(keys_t'{speed_reset: 1'b1, default: 1'b0});
    repeat (4) press_key(keys_t'{speed_up: 1'b1, default: 1'b0});
    wait_samples(4);
    press_key(keys_t'{speed_reset: 1'b1, default: 1'b0});
    // Backward through the wrap from 0 to 15
    press_key(keys_t'{dir: 1'b1, default: 1'b0});
    wait_samples(20);
    press_key(keys_t'{play: 1'b1, default: 1'b0});
    repeat (100) step_cycle();  // Paused
    press_key(keys_t'{play: 1'b1, default: 1'b0});
    wait_samples(4);
    press_key(keys_t'{dir: 1'b1, default: 1'b0});
    wait_samples(6);
    if (dut0.u_asserts.fail_count == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("*** TEST FAILED ***");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/ipod_pkg.sv
src/key_decode.sv
src/playback_execute.sv
src/sample_result.sv
src/ipod_top.sv
bench/tb_clock.sv
bench/ipod_asserts.sv
bench/tb_ipod.sv
